// File: all.f
+incdir+bench
design/imuldiv_pkg.sv
design/step_counter.sv
design/muldiv_ctrl.sv
design/mul_dpath.sv
design/div_dpath.sv
design/imuldiv_iterative.sv
bench/imuldiv_tb.sv

// File: bench/imuldiv_model.svh
// reference model for the iterative mul/div unit
// expected product, quotient and remainder from a request alone

`ifndef IMULDIV_MODEL_SVH
`define IMULDIV_MODEL_SVH

// full 64-bit signed product
function automatic imuldiv_pkg::muldiv_resp_t model_product(imuldiv_pkg::muldiv_req_t r);
  logic signed [63:0] sa;
  logic signed [63:0] sb;
  imuldiv_pkg::muldiv_resp_t res;
  sa = $signed(r.a);
  sb = $signed(r.b);
  res.result = sa * sb;
  return res;
endfunction

// remainder in the upper half, quotient in the lower half
function automatic imuldiv_pkg::muldiv_resp_t model_divide(imuldiv_pkg::muldiv_req_t r);
  logic signed [31:0] sa;
  logic signed [31:0] sb;
  imuldiv_pkg::muldiv_resp_t res;
  sa = $signed(r.a);
  sb = $signed(r.b);
  if (r.b == 32'd0) begin
    // zero divisor: all-ones quotient, dividend as remainder
    res.result = {r.a, 32'hffff_ffff};
  end else if (r.op == imuldiv_pkg::op_divu) begin
    res.result = {r.a % r.b, r.a / r.b};
  end else if (r.a == 32'h8000_0000 && r.b == 32'hffff_ffff) begin
    // signed overflow returns the dividend, no remainder
    res.result = {32'd0, r.a};
  end else begin
    // truncating divide, so the remainder follows the dividend's sign
    res.result = {32'(sa % sb), 32'(sa / sb)};
  end
  return res;
endfunction

function automatic imuldiv_pkg::muldiv_resp_t expected_resp(imuldiv_pkg::muldiv_req_t r);
  if (r.op == imuldiv_pkg::op_mul) begin
    return model_product(r);
  end
  return model_divide(r);
endfunction

`endif

// File: bench/imuldiv_tb.sv
// testbench for the iterative mul/div unit
// directed corners, seeded random requests, back-pressure and watchdog

`timescale 1ns/1ps

module imuldiv_tb;

  localparam int clk_period = 100;
  localparam int n_directed = 10;
  localparam int n_random   = 80;
  localparam int n_txn      = n_directed + n_random;
  // longest random hold of resp_rdy low
  localparam int max_stall  = 6;
  // response latency in cycles counting the accepting cycle as the first
  localparam int latency    = imuldiv_pkg::steps + 1;
  // per transaction the latency and stall plus release, take, drive and accept edges
  localparam int txn_cycles = latency + max_stall + 2 + 2;
  localparam int wd_cycles  = n_txn * txn_cycles + 3 + 8;

  logic                      clk;
  logic                      reset;
  imuldiv_pkg::muldiv_req_t  req;
  logic                      req_val;
  logic                      req_rdy;
  imuldiv_pkg::muldiv_resp_t resp;
  logic                      resp_val;
  logic                      resp_rdy;

  integer seed;

  `include "imuldiv_model.svh"

  imuldiv_iterative UUT (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp     (resp),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  always #(clk_period / 2) clk = ~clk;

  // ----------------------------------------
  // checks
  // ----------------------------------------

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Result: FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_resp(input string name, input imuldiv_pkg::muldiv_resp_t exp,
                            input imuldiv_pkg::muldiv_resp_t act);
    if (act !== exp) begin
      abort_run($sformatf("Mismatch %s: expected %h, actual %h", name, exp.result, act.result));
    end
  endtask

  task automatic check_latency(input string name, input int exp, input int act);
    if (act != exp) begin
      abort_run($sformatf("Mismatch %s latency: expected %0d, actual %0d", name, exp, act));
    end
  endtask

  // ----------------------------------------
  // one request and its response
  // ----------------------------------------

  // outputs sampled on the falling edge away from the DUT's updates
  task automatic run_txn(input string name, input imuldiv_pkg::muldiv_req_t r, input int stall);
    int cycles;
    imuldiv_pkg::muldiv_resp_t exp;
    imuldiv_pkg::muldiv_resp_t held;
    exp = expected_resp(r);
    @(posedge clk);
    req     <= r;
    req_val <= 1'b1;
    @(negedge clk);
    while (!req_rdy) begin
      @(negedge clk);
    end
    // accepting edge
    @(posedge clk);
    req_val  <= 1'b0;
    req      <= '0;
    resp_rdy <= (stall == 0);
    // the cycle that starts here is the first one
    cycles = 1;
    do begin
      @(posedge clk);
      cycles++;
      @(negedge clk);
      if (req_rdy) begin
        abort_run({"req_rdy went high while the unit was busy in ", name});
      end
      if (cycles > latency + 8) begin
        abort_run({"no response arrived for ", name});
      end
    end while (!resp_val);
    check_latency(name, latency, cycles);
    check_resp(name, exp, resp);
    held = resp;
    // response must sit still under back-pressure
    for (int i = 0; i < stall; i++) begin
      @(posedge clk);
      @(negedge clk);
      if (!resp_val || req_rdy) begin
        abort_run({"handshake moved while the response was stalled in ", name});
      end
      check_resp(name, held, resp);
    end
    if (stall > 0) begin
      @(posedge clk);
      resp_rdy <= 1'b1;
    end
    // response taken on this edge
    @(posedge clk);
    resp_rdy <= 1'b0;
    @(negedge clk);
    if (resp_val || !req_rdy) begin
      abort_run({"unit did not return to idle after the response of ", name});
    end
  endtask

  function automatic imuldiv_pkg::muldiv_req_t make_req(input imuldiv_pkg::muldiv_op_e op,
                                                      input logic [31:0] a,
                                                      input logic [31:0] b);
    imuldiv_pkg::muldiv_req_t r;
    r.op = op;
    r.a  = a;
    r.b  = b;
    return r;
  endfunction

  // ----------------------------------------
  // main sequence
  // ----------------------------------------

  initial begin
    imuldiv_pkg::muldiv_op_e op;
    logic [31:0] a;
    logic [31:0] b;
    int stall;
    clk       = 1'b0;
    reset     = 1'b1;
    req       = '0;
    req_val   = 1'b0;
    resp_rdy  = 1'b0;
    seed      = 63302;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    if (!req_rdy || resp_val) begin
      abort_run("after reset req_rdy should be high and resp_val low");
    end

    // corner operands
    run_txn("div_by_zero", make_req(imuldiv_pkg::op_div, 32'hffff_ff85, 32'd0), 0);
    run_txn("divu_by_zero", make_req(imuldiv_pkg::op_divu, 32'h8000_0001, 32'd0), 2);
    run_txn("div_overflow", make_req(imuldiv_pkg::op_div, 32'h8000_0000, 32'hffff_ffff), 0);
    run_txn("divu_min_by_ones", make_req(imuldiv_pkg::op_divu, 32'h8000_0000, 32'hffff_ffff), 0);
    run_txn("mul_min_min", make_req(imuldiv_pkg::op_mul, 32'h8000_0000, 32'h8000_0000), 1);
    run_txn("mul_zero_a", make_req(imuldiv_pkg::op_mul, 32'd0, 32'hdead_beef), 0);
    run_txn("mul_zero_b", make_req(imuldiv_pkg::op_mul, 32'h8765_4321, 32'd0), 0);
    run_txn("div_zero_a", make_req(imuldiv_pkg::op_div, 32'd0, 32'hffff_fff9), 0);
    run_txn("div_neg_rem", make_req(imuldiv_pkg::op_div, 32'hffff_fff9, 32'd2), 3);
    run_txn("mul_neg_pos", make_req(imuldiv_pkg::op_mul, 32'hffff_ffff, 32'h7fff_ffff), 0);

    // random requests with random back-pressure
    for (int i = 0; i < n_random; i++) begin
      case ({$random(seed)} % 3)
        0: op = imuldiv_pkg::op_mul;
        1: op = imuldiv_pkg::op_div;
        default: op = imuldiv_pkg::op_divu;
      endcase
      a = $random(seed);
      b = $random(seed);
      // narrow the divisor now and then so quotients get large
      if ($random(seed) & 1) begin
        b = $signed(b) >>> ({$random(seed)} % 32);
      end
      stall = ($random(seed) & 1) ? ({$random(seed)} % (max_stall + 1)) : 0;
      run_txn($sformatf("rand_%0d", i), make_req(op, a, b), stall);
    end

    $display("Result: PASSED");
    $finish;
  end

  // ----------------------------------------
  // watchdog
  // ----------------------------------------

  initial begin
    #(wd_cycles * clk_period);
    abort_run("watchdog expired, the run hung waiting on the DUT");
  end

endmodule

// File: design/imuldiv_iterative.sv
// top level of the iterative mul/div unit
// controller, step counter, both datapaths and the result mux

`timescale 1ns/1ps

module imuldiv_iterative (
  input  logic                      clk,
  input  logic                      reset,
  input  imuldiv_pkg::muldiv_req_t  req,
  input  logic                      req_val,
  output logic                      req_rdy,
  output imuldiv_pkg::muldiv_resp_t resp,
  output logic                      resp_val,
  input  logic                      resp_rdy
);

  imuldiv_pkg::dpath_ctrl_t            dctl;
  logic                                cnt_start;
  logic                                cnt_en;
  logic                                last;
  logic [2*imuldiv_pkg::xlen-1:0]      mul_result;
  logic [2*imuldiv_pkg::xlen-1:0]      div_result;

  // ----------------------------------------
  // control
  // ----------------------------------------

  muldiv_ctrl ctrl (
    .clk       (clk),
    .reset     (reset),
    .req_op    (req.op),
    .req_val   (req_val),
    .req_rdy   (req_rdy),
    .resp_val  (resp_val),
    .resp_rdy  (resp_rdy),
    .last      (last),
    .cnt_start (cnt_start),
    .cnt_en    (cnt_en),
    .dctl      (dctl)
  );

  // times the 32 calc cycles
  step_counter counter (
    .clk   (clk),
    .reset (reset),
    .start (cnt_start),
    .en    (cnt_en),
    .last  (last)
  );

  // ----------------------------------------
  // datapaths
  // ----------------------------------------

  // both capture every request, only the selected one is returned
  mul_dpath mul (
    .clk    (clk),
    .reset  (reset),
    .load   (dctl.load),
    .step   (dctl.step),
    .req    (req),
    .result (mul_result)
  );

  div_dpath div (
    .clk    (clk),
    .reset  (reset),
    .load   (dctl.load),
    .step   (dctl.step),
    .req    (req),
    .result (div_result)
  );

  // select held stable while the response waits
  assign resp.result = dctl.use_div ? div_result : mul_result;

endmodule

// File: design/div_dpath.sv
// restoring divide datapath, signed or unsigned
// zero-divisor substitution and remainder/quotient sign fixes

`timescale 1ns/1ps

module div_dpath (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     load,
  input  logic                     step,
  input  imuldiv_pkg::muldiv_req_t req,
  output logic [2*imuldiv_pkg::xlen-1:0] result
);

  localparam int w = imuldiv_pkg::xlen;

  // raw dividend, returned as remainder on a zero divisor
  logic [w-1:0] dividend_q;
  logic [w-1:0] divisor_q;
  // dividend bits shift out the top, quotient bits shift in below
  logic [w-1:0] quo;
  logic [w-1:0] rem;
  logic         neg_quo_q;
  logic         neg_rem_q;
  logic         zero_div_q;

  logic         signed_mode;
  logic         sign_a;
  logic         sign_b;
  logic [w-1:0] mag_a;
  logic [w-1:0] mag_b;
  logic [w:0]   shifted;
  logic [w+1:0] diff;
  logic         q_bit;
  logic [w-1:0] quo_out;
  logic [w-1:0] rem_out;

  // ----------------------------------------
  // operand decode at load
  // ----------------------------------------

  assign signed_mode = (req.op == imuldiv_pkg::op_div);

  // unsigned mode treats the top bit as magnitude
  assign sign_a = signed_mode && req.a[w-1];
  assign sign_b = signed_mode && req.b[w-1];
  assign mag_a  = sign_a ? (~req.a + 1'b1) : req.a;
  assign mag_b  = sign_b ? (~req.b + 1'b1) : req.b;

  // ----------------------------------------
  // one restoring step
  // ----------------------------------------

  // partial remainder with the next dividend bit, needs one extra bit
  assign shifted = {rem, quo[w-1]};
  // trial subtract, top bit set means it went negative
  assign diff    = {1'b0, shifted} - {2'b00, divisor_q};
  assign q_bit   = ~diff[w+1];

  always_ff @(posedge clk) begin
    if (reset) begin
      neg_quo_q  <= 1'b0;
      neg_rem_q  <= 1'b0;
      zero_div_q <= 1'b0;
    end else if (load) begin
      neg_quo_q  <= sign_a ^ sign_b;
      // remainder follows the dividend
      neg_rem_q  <= sign_a;
      zero_div_q <= (req.b == '0);
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      dividend_q <= req.a;
      divisor_q  <= mag_b;
      quo        <= mag_a;
      rem        <= '0;
    end else if (step) begin
      quo <= {quo[w-2:0], q_bit};
      // restore by keeping the shifted value when the subtract failed
      rem <= q_bit ? diff[w-1:0] : shifted[w-1:0];
    end
  end

  // ----------------------------------------
  // output
  // ----------------------------------------

  // min / -1 lands on 2^31 with a positive sign, i.e. the dividend
  assign quo_out = neg_quo_q ? (~quo + 1'b1) : quo;
  assign rem_out = neg_rem_q ? (~rem + 1'b1) : rem;

  // zero divisor: remainder is the dividend, quotient all ones
  assign result = zero_div_q ? {dividend_q, {w{1'b1}}} : {rem_out, quo_out};

  // ----------------------------------------
  // checks
  // ----------------------------------------

  a_load_step_excl : assert property (
    @(posedge clk) disable iff (reset)
    !(load && step)
  );

endmodule

// File: design/mul_dpath.sv
// signed shift-add multiply datapath
// works on operand magnitudes, sign fixed on the output

`timescale 1ns/1ps

module mul_dpath (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     load,
  input  logic                     step,
  input  imuldiv_pkg::muldiv_req_t req,
  output logic [2*imuldiv_pkg::xlen-1:0] result
);

  // multiplicand, widened so it can shift into the upper half
  logic [2*imuldiv_pkg::xlen-1:0] mcand;
  // multiplier, consumed one bit per step from the bottom
  logic [imuldiv_pkg::xlen-1:0]   mplier;
  logic [2*imuldiv_pkg::xlen-1:0] acc;
  // product is negative when exactly one operand is
  logic                           neg_q;

  logic                           sign_a;
  logic                           sign_b;
  logic [imuldiv_pkg::xlen-1:0]   mag_a;
  logic [imuldiv_pkg::xlen-1:0]   mag_b;
  logic [2*imuldiv_pkg::xlen-1:0] acc_next;

  // ----------------------------------------
  // operand magnitudes
  // ----------------------------------------

  assign sign_a = req.a[imuldiv_pkg::xlen-1];
  assign sign_b = req.b[imuldiv_pkg::xlen-1];

  // most negative value maps to 2^31, still fits unsigned
  assign mag_a = sign_a ? (~req.a + 1'b1) : req.a;
  assign mag_b = sign_b ? (~req.b + 1'b1) : req.b;

  // add the shifted multiplicand when the current multiplier bit is set
  assign acc_next = mplier[0] ? (acc + mcand) : acc;

  // ----------------------------------------
  // iteration registers
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      acc   <= '0;
      neg_q <= 1'b0;
    end else if (load) begin
      acc   <= '0;
      neg_q <= sign_a ^ sign_b;
    end else if (step) begin
      acc <= acc_next;
    end
  end

  // shift registers carry no reset, loaded before every run
  always_ff @(posedge clk) begin
    if (load) begin
      mcand  <= {{imuldiv_pkg::xlen{1'b0}}, mag_a};
      mplier <= mag_b;
    end else if (step) begin
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  // ----------------------------------------
  // output
  // ----------------------------------------

  // two's complement of the magnitude product
  assign result = neg_q ? (~acc + 1'b1) : acc;

endmodule

// File: design/muldiv_ctrl.sv
// control FSM for the iterative mul/div unit
// handshake, datapath strobes, step counter control, result select

`timescale 1ns/1ps

module muldiv_ctrl (
  input  logic                     clk,
  input  logic                     reset,
  input  imuldiv_pkg::muldiv_op_e  req_op,
  input  logic                     req_val,
  output logic                     req_rdy,
  output logic                     resp_val,
  input  logic                     resp_rdy,
  input  logic                     last,
  output logic                     cnt_start,
  output logic                     cnt_en,
  output imuldiv_pkg::dpath_ctrl_t dctl
);

  imuldiv_pkg::ctrl_state_e state;
  imuldiv_pkg::ctrl_state_e state_next;

  // result select held from acceptance until the response is taken
  logic use_div_q;

  logic req_go;
  logic resp_go;

  assign req_go  = req_val && req_rdy;
  assign resp_go = resp_val && resp_rdy;

  // ----------------------------------------
  // state register
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= imuldiv_pkg::st_idle;
      use_div_q <= 1'b0;
    end else begin
      state <= state_next;
      // both divide opcodes steer the mux to the divider
      if (req_go) begin
        use_div_q <= (req_op != imuldiv_pkg::op_mul);
      end
    end
  end

  // ----------------------------------------
  // next state
  // ----------------------------------------

  always_comb begin
    state_next = state;
    unique case (state)
      imuldiv_pkg::st_idle: begin
        if (req_go) begin
          state_next = imuldiv_pkg::st_calc;
        end
      end
      imuldiv_pkg::st_calc: begin
        // counter ends the phase after 32 steps
        if (last) begin
          state_next = imuldiv_pkg::st_done;
        end
      end
      imuldiv_pkg::st_done: begin
        // stall here under back-pressure
        if (resp_go) begin
          state_next = imuldiv_pkg::st_idle;
        end
      end
      default: begin
        state_next = imuldiv_pkg::st_idle;
      end
    endcase
  end

  // ----------------------------------------
  // decoded outputs
  // ----------------------------------------

  assign req_rdy  = (state == imuldiv_pkg::st_idle);
  assign resp_val = (state == imuldiv_pkg::st_done);

  // operands captured on the accepting edge
  assign dctl.load    = req_go;
  // one iteration per calc cycle
  assign dctl.step    = (state == imuldiv_pkg::st_calc);
  assign dctl.use_div = use_div_q;

  // counter restarts with the load and runs alongside step
  assign cnt_start = req_go;
  assign cnt_en    = dctl.step;

  // ----------------------------------------
  // checks
  // ----------------------------------------

  a_rdy_val_excl : assert property (
    @(posedge clk) disable iff (reset)
    !(resp_val && req_rdy)
  );

  // step only runs from acceptance until the counter flags the final step
  a_step_in_calc : assert property (
    @(posedge clk) disable iff (reset)
    dctl.step |-> ($past(req_go) || ($past(dctl.step) && !$past(last)))
  );

  // a stalled response stays up until it is taken
  a_resp_hold : assert property (
    @(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> resp_val
  );

endmodule

// File: design/step_counter.sv
// step counter for the iterative unit
// flags the final step of a 32-step operation

`timescale 1ns/1ps

module step_counter (
  input  logic clk,
  input  logic reset,
  input  logic start,
  input  logic en,
  output logic last
);

  logic [imuldiv_pkg::count_w-1:0] count;

  // ----------------------------------------
  // counter register
  // ----------------------------------------

  // start wins on the accepting edge, en advances during calc
  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (start) begin
      count <= '0;
    end else if (en) begin
      // wraps back to zero after the final step
      count <= count + 1'b1;
    end
  end

  // high in the 32nd enabled cycle only
  assign last = en && (count == imuldiv_pkg::last_count);

  // ----------------------------------------
  // checks
  // ----------------------------------------

  // the controller restarts only from idle, never mid-run
  a_start_en_excl : assert property (
    @(posedge clk) disable iff (reset)
    !(start && en)
  );

endmodule

// File: design/imuldiv_pkg.sv
// shared widths, opcode and state enums for the iterative mul/div unit
// request, response and datapath-control structs

package imuldiv_pkg;

  // ----------------------------------------
  // widths
  // ----------------------------------------

  // operand width
  localparam int xlen = 32;
  // iterations per operation, one bit per step
  localparam int steps = 32;
  // step counter width
  localparam int count_w = 5;
  // counter value in the final step
  localparam logic [count_w-1:0] last_count = count_w'(steps - 1);

  // ----------------------------------------
  // enums
  // ----------------------------------------

  // op_div is signed, op_divu unsigned
  typedef enum logic [1:0] {
    op_mul  = 2'd0,
    op_div  = 2'd1,
    op_divu = 2'd2
  } muldiv_op_e;

  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_calc = 2'd1,
    st_done = 2'd2
  } ctrl_state_e;

  // ----------------------------------------
  // structs
  // ----------------------------------------

  // 66 bits, op in the top two
  typedef struct packed {
    muldiv_op_e        op;
    logic [xlen-1:0]   a;
    logic [xlen-1:0]   b;
  } muldiv_req_t;

  // divide: remainder in the upper half, quotient in the lower half
  typedef struct packed {
    logic [2*xlen-1:0] result;
  } muldiv_resp_t;

  typedef struct packed {
    logic load;
    logic step;
    logic use_div;
  } dpath_ctrl_t;

endpackage
